//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module wm_tb -f wm.f -o wm_sim \
    > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/wm_sim > sim.log 2>&1 || echo "Simulator exited with an error status"
grep -qF '*** PASSED ***' sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- testbench/wm_checker.sv
`timescale 1ns/100ps

module wm_checker (
    input logic                   clk,
    input logic                   rstb,
    input logic                   bvalid,
    input logic                   bready,
    input logic [1:0]             bresp,
    input logic                   rvalid,
    input logic                   rready,
    input logic [31:0]            rdata,
    input logic [1:0]             rresp,
    input logic                   exec,
    input wm_pkg::manager_state_t state
);

    // A response waits for its ready without changing.
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rstb)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("BVALID dropped or BRESP changed before BREADY");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rstb)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("RVALID dropped or read payload changed before RREADY");

    a_idle_in_reset: assert property (@(posedge clk) !rstb |-> !bvalid && !rvalid)
        else $error("Response valid seen during reset");

    a_halt_hold: assert property (@(posedge clk) disable iff (!rstb)
        state == wm_pkg::HALT && exec |=> state == wm_pkg::HALT)
        else $error("Manager left HALT while exec was high");

    a_ready_exec: assert property (@(posedge clk) disable iff (!rstb)
        state == wm_pkg::READY && exec |=> state == wm_pkg::HALT)
        else $error("Manager did not enter HALT after exec");

endmodule : wm_checker

bind wm_top wm_checker i_checker (
    .clk    (clk),
    .rstb   (rstb),
    .bvalid (bvalid),
    .bready (bready),
    .bresp  (bresp),
    .rvalid (rvalid),
    .rready (rready),
    .rdata  (rdata),
    .rresp  (rresp),
    .exec   (exec),
    .state  (u_manager.state)
);

//--- testbench/wm_tb.sv
`timescale 1ns/100ps

module wm_tb;

    localparam int TIMEOUT_CYCLES = 64;
    localparam int NUM_RANDOM     = 24;

    logic        clk;
    logic        rstb;
    logic [5:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [5:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    int errors;
    int checks;
    int tests;
    bit hung;

    // Reference model of the weight store, indexed [lane][col].
    logic signed [7:0] model_w [8][4];
    logic signed [7:0] model_read;
    logic [31:0]       model_in;

    wm_top i_dut (
        .clk     (clk),
        .rstb    (rstb),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (hung) return;
        checks++;
        assert (got === exp) else begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_hang(input string what);
        $display("Timeout while waiting for %s", what);
        hung = 1'b1;
        errors++;
    endtask

    task automatic axi_write(input logic [5:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        bit aw_pend;
        bit w_pend;
        bit aw_hit;
        bit w_hit;
        bit done;
        int wait_cycles;
        int delay;
        resp = 2'b11;
        if (hung) return;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hF;
        wvalid  <= 1'b1;
        aw_pend = 1'b1;
        w_pend  = 1'b1;
        wait_cycles = 0;
        while (aw_pend || w_pend) begin
            @(negedge clk);
            aw_hit = aw_pend && awready; // Transfers on the coming rising edge.
            w_hit  = w_pend && wready;
            @(posedge clk);
            if (aw_hit) begin
                awvalid <= 1'b0;
                aw_pend = 1'b0;
            end
            if (w_hit) begin
                wvalid <= 1'b0;
                w_pend = 1'b0;
            end
            wait_cycles++;
            if ((aw_pend || w_pend) && wait_cycles > TIMEOUT_CYCLES) begin
                awvalid <= 1'b0;
                wvalid  <= 1'b0;
                report_hang($sformatf("the write address and data at 0x%h", addr));
                return;
            end
        end
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge clk); // Holds the response back for a while.
        bready <= 1'b1;
        done = 1'b0;
        wait_cycles = 0;
        while (!done) begin
            @(negedge clk);
            if (bvalid) begin
                resp = bresp;
                done = 1'b1;
            end
            @(posedge clk);
            wait_cycles++;
            if (!done && wait_cycles > TIMEOUT_CYCLES) begin
                bready <= 1'b0;
                report_hang($sformatf("the write response at 0x%h", addr));
                return;
            end
        end
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [5:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        bit done;
        int wait_cycles;
        int delay;
        data = '0;
        resp = 2'b11;
        if (hung) return;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        done = 1'b0;
        wait_cycles = 0;
        while (!done) begin
            @(negedge clk);
            done = arready;
            @(posedge clk);
            wait_cycles++;
            if (!done && wait_cycles > TIMEOUT_CYCLES) begin
                arvalid <= 1'b0;
                report_hang($sformatf("the read address at 0x%h", addr));
                return;
            end
        end
        arvalid <= 1'b0;
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge clk);
        rready <= 1'b1;
        done = 1'b0;
        wait_cycles = 0;
        while (!done) begin
            @(negedge clk);
            if (rvalid) begin
                data = rdata;
                resp = rresp;
                done = 1'b1;
            end
            @(posedge clk);
            wait_cycles++;
            if (!done && wait_cycles > TIMEOUT_CYCLES) begin
                rready <= 1'b0;
                report_hang($sformatf("the read data at 0x%h", addr));
                return;
            end
        end
        rready <= 1'b0;
    endtask

    task automatic write_reg(input logic [5:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check_value($sformatf("BRESP@%h", addr), 32'(resp), 32'(wm_pkg::RESP_OKAY));
    endtask

    task automatic read_expect(input string name, input logic [5:0] addr,
                               input logic [31:0] exp);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        check_value({"RRESP ", name}, 32'(resp), 32'(wm_pkg::RESP_OKAY));
        check_value({"RDATA ", name}, data, exp);
    endtask

    function automatic logic [31:0] sext8(input logic [7:0] v);
        return {{24{v[7]}}, v};
    endfunction

    // Column sum over all lanes, wrapped to 16 bits and sign extended.
    function automatic logic [31:0] expected_sum(input int col);
        int          acc;
        logic [15:0] low;
        acc = 0;
        for (int l = 0; l < 8; l++) begin
            acc += int'(model_w[l][col]) * int'($signed(model_in[4*l +: 4]));
        end
        low = acc[15:0];
        return {{16{low[15]}}, low};
    endfunction

    function automatic void apply_model(input logic op, input logic [2:0] lane,
                                        input logic [1:0] col, input logic [15:0] data);
        logic [1:0] inc;
        model_read = model_w[lane][col];
        if (op == wm_pkg::OP_INCREMENT) begin
            for (int l = 0; l < 8; l++) begin
                inc = data[2*l +: 2];
                model_w[l][col] = model_w[l][col] + {{6{inc[1]}}, inc};
            end
        end else begin
            model_w[lane][col] = data[7:0];
        end
    endfunction

    task automatic run_command(input logic op, input logic [2:0] lane,
                               input logic [1:0] col, input logic [15:0] data);
        write_reg(wm_pkg::ADDR_DATA, 32'(data));
        write_reg(wm_pkg::ADDR_INST, {26'b0, op, lane, col});
        write_reg(wm_pkg::ADDR_CTRL, 32'd1);
        apply_model(op, lane, col, data);
        write_reg(wm_pkg::ADDR_CTRL, 32'd0);
    endtask

    task automatic set_inputs(input logic [31:0] v);
        write_reg(wm_pkg::ADDR_INPUT, v);
        model_in = v;
    endtask

    task automatic check_sums();
        for (int c = 0; c < 4; c++) begin
            read_expect($sformatf("SUM%0d", c), wm_pkg::ADDR_SUM0 + 6'(4 * c), expected_sum(c));
        end
    endtask

    // A one-hot input of 1 makes each sum equal to one lane's weight.
    task automatic scan_weights();
        logic [31:0] saved;
        saved = model_in;
        for (int l = 0; l < 8; l++) begin
            set_inputs(32'h1 << (4 * l));
            check_sums();
        end
        set_inputs(saved);
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests++;
        $display("Test %0d %s finished with %0d errors", tests, name, errors - start_errors);
    endtask

    initial begin
        int          start;
        logic [5:0]  addr;
        logic [31:0] rd;
        logic [1:0]  resp;
        errors = 0;
        checks = 0;
        tests  = 0;
        hung   = 1'b0;
        void'($urandom(95242));
        rstb    = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        model_read = '0;
        model_in   = '0;
        for (int l = 0; l < 8; l++) begin
            for (int c = 0; c < 4; c++) model_w[l][c] = '0;
        end
        repeat (10) @(posedge clk);
        rstb <= 1'b1;

        start = errors;
        read_expect("READ", wm_pkg::ADDR_READ, 32'h0);
        read_expect("INPUT", wm_pkg::ADDR_INPUT, 32'h0);
        check_sums();
        finish_test("reset_values", start);

        start = errors;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            run_command(wm_pkg::OP_SET, 3'($urandom_range(7, 0)), 2'($urandom_range(3, 0)),
                        16'($urandom()));
            read_expect("READ", wm_pkg::ADDR_READ, sext8(model_read));
        end
        scan_weights();
        finish_test("set_weights", start);

        start = errors;
        set_inputs($urandom());
        for (int n = 0; n < NUM_RANDOM; n++) begin
            run_command(wm_pkg::OP_INCREMENT, 3'($urandom_range(7, 0)),
                        2'($urandom_range(3, 0)), 16'($urandom()));
            read_expect("READ", wm_pkg::ADDR_READ, sext8(model_read));
            check_sums();
        end
        scan_weights();
        finish_test("increment_columns", start);

        // The second command is loaded while the manager sits in HALT.
        start = errors;
        write_reg(wm_pkg::ADDR_DATA, 32'h0000_005A);
        write_reg(wm_pkg::ADDR_INST, {26'b0, wm_pkg::OP_SET, 3'd5, 2'd2});
        write_reg(wm_pkg::ADDR_CTRL, 32'd1);
        apply_model(wm_pkg::OP_SET, 3'd5, 2'd2, 16'h005A);
        write_reg(wm_pkg::ADDR_DATA, $urandom() | 32'h1);
        write_reg(wm_pkg::ADDR_INST, {26'b0, wm_pkg::OP_INCREMENT, 3'd1, 2'd2});
        write_reg(wm_pkg::ADDR_CTRL, 32'd1);
        read_expect("READ", wm_pkg::ADDR_READ, sext8(model_read));
        scan_weights();
        write_reg(wm_pkg::ADDR_CTRL, 32'd0);
        read_expect("READ", wm_pkg::ADDR_READ, sext8(model_read));
        scan_weights();
        finish_test("halt_until_exec_low", start);

        start = errors;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            set_inputs($urandom());
            read_expect("INPUT", wm_pkg::ADDR_INPUT, model_in);
            check_sums();
        end
        finish_test("dot_product", start);

        start = errors;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (n % 2 == 0) begin
                addr = 6'h24 + 6'($urandom_range(27, 0)); // Above the last sum.
            end else begin
                addr = {4'($urandom_range(8, 0)), 2'($urandom_range(3, 1))};
            end
            axi_write(addr, $urandom(), resp);
            check_value($sformatf("BRESP@%h", addr), 32'(resp), 32'(wm_pkg::RESP_SLVERR));
            axi_read(addr, rd, resp);
            check_value($sformatf("RRESP@%h", addr), 32'(resp), 32'(wm_pkg::RESP_SLVERR));
            check_value($sformatf("RDATA@%h", addr), rd, 32'h0);
        end
        read_expect("READ", wm_pkg::ADDR_READ, sext8(model_read));
        scan_weights();
        finish_test("unmapped_access", start);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : wm_tb

//--- verilog/dot_product_array.sv
`timescale 1ns/100ps

module dot_product_array (
    input  logic                clk,
    input  logic                rstb,
    input  wm_pkg::wm_weights_t weights,
    input  wm_pkg::wm_inputs_t  inputs,
    output wm_pkg::wm_sums_t    sums
);

    wm_pkg::wm_sums_t sums_next;

    // Sum over all lanes of weight times input for one column.
    function automatic logic [wm_pkg::WM_SUM_BITS-1:0] column_sum(
        input wm_pkg::wm_weights_t      w,
        input wm_pkg::wm_inputs_t       x,
        input int                       col
    );
        logic signed [wm_pkg::WM_BITWIDTH+wm_pkg::WM_IN_BITS-1:0] prod;
        logic signed [wm_pkg::WM_SUM_BITS-1:0]                   acc;
        acc = '0;
        for (int lane = 0; lane < wm_pkg::WM_WIDTH; lane++) begin
            prod = $signed(w[lane][col]) * $signed(x[lane]);
            acc  = acc + wm_pkg::WM_SUM_BITS'(prod); // Sign extended before adding.
        end
        return acc;
    endfunction

    always_comb begin
        for (int c = 0; c < wm_pkg::WM_DEPTH; c++) begin
            sums_next[c] = column_sum(weights, inputs, c);
        end
    end

    // One register stage after the weights or inputs change.
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            sums <= '0;
        end else begin
            sums <= sums_next;
        end
    end

endmodule : dot_product_array

//--- verilog/weight_manager.sv
`timescale 1ns/100ps

module weight_manager (
    input  logic                                  clk,
    input  logic                                  rstb,
    input  wm_pkg::wm_cmd_t                       cmd,
    input  logic                                  exec,
    output logic signed [wm_pkg::WM_BITWIDTH-1:0] read_reg,
    output wm_pkg::wm_weights_t                   weights
);

    wm_pkg::manager_state_t state;

    // The addressed column after the command is applied.
    logic [wm_pkg::WM_WIDTH-1:0][wm_pkg::WM_BITWIDTH-1:0] next_col;

    always_comb begin
        logic signed [wm_pkg::WM_BITWIDTH-1:0] step;
        for (int i = 0; i < wm_pkg::WM_WIDTH; i++) begin
            step = wm_pkg::WM_BITWIDTH'($signed(cmd.data[2*i +: 2]));
            if (cmd.op == wm_pkg::OP_INCREMENT) begin
                // Wraps at the weight width, no saturation.
                next_col[i] = weights[i][cmd.col] + step;
            end else if (cmd.lane == wm_pkg::WM_LANE_BITS'(i)) begin
                next_col[i] = cmd.data[wm_pkg::WM_BITWIDTH-1:0];
            end else begin
                next_col[i] = weights[i][cmd.col];
            end
        end
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            state    <= wm_pkg::READY;
            weights  <= '0;
            read_reg <= '0;
        end else begin
            case (state)
                wm_pkg::READY: begin
                    if (exec) begin
                        for (int i = 0; i < wm_pkg::WM_WIDTH; i++) begin
                            weights[i][cmd.col] <= next_col[i];
                        end
                        read_reg <= $signed(weights[cmd.lane][cmd.col]); // Value before the update.
                        state    <= wm_pkg::HALT;
                    end
                end
                wm_pkg::HALT: begin
                    // Exec must drop before another command can run.
                    if (!exec) state <= wm_pkg::READY;
                end
                default: state <= wm_pkg::READY;
            endcase
        end
    end

endmodule : weight_manager

//--- verilog/wm_axil_regs.sv
`timescale 1ns/100ps

module wm_axil_regs (
    input  logic                                  clk,
    input  logic                                  rstb,
    input  logic [wm_pkg::AXI_ADDR_BITS-1:0]      awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [wm_pkg::AXI_DATA_BITS-1:0]      wdata,
    input  logic [wm_pkg::AXI_DATA_BITS/8-1:0]    wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [wm_pkg::AXI_ADDR_BITS-1:0]      araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [wm_pkg::AXI_DATA_BITS-1:0]      rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready,
    output wm_pkg::wm_cmd_t                       cmd,
    output logic                                  exec,
    output wm_pkg::wm_inputs_t                    inputs,
    input  logic signed [wm_pkg::WM_BITWIDTH-1:0] read_reg,
    input  wm_pkg::wm_sums_t                      sums
);

    logic                                 aw_done;
    logic                                 w_done;
    logic                                 ar_done;
    logic [wm_pkg::AXI_ADDR_BITS-1:0]     aw_addr_q;
    logic [wm_pkg::AXI_DATA_BITS-1:0]     w_data_q;
    logic [wm_pkg::AXI_DATA_BITS/8-1:0]   w_strb_q;
    logic [wm_pkg::AXI_ADDR_BITS-1:0]     ar_addr_q;

    logic [wm_pkg::WM_DATA_BITS-1:0]      data_reg;
    logic [wm_pkg::WM_INST_BITS-1:0]      inst_reg;
    logic                                 exec_reg;
    wm_pkg::wm_inputs_t                   inputs_reg;

    logic                                 wr_commit;
    logic                                 wr_full;
    logic [wm_pkg::AXI_DATA_BITS-1:0]     rd_value;
    logic [wm_pkg::AXI_ADDR_BITS-1:0]     sum_offset;

    // Word-aligned and no higher than the last sum register.
    function automatic logic in_map(input logic [wm_pkg::AXI_ADDR_BITS-1:0] addr);
        in_map = (addr[1:0] == 2'b00) &&
                 (addr <= wm_pkg::ADDR_SUM0 + 4 * (wm_pkg::WM_DEPTH - 1));
    endfunction

    assign awready   = ~bvalid & ~aw_done;
    assign wready    = ~bvalid & ~w_done;
    assign arready   = ~rvalid & ~ar_done;
    assign wr_commit = aw_done & w_done;
    assign wr_full   = (w_strb_q == '1); // Partial writes are dropped.

    assign cmd.op   = wm_pkg::wm_op_t'(inst_reg[wm_pkg::WM_INST_BITS-1]);
    assign cmd.lane = inst_reg[wm_pkg::WM_COL_BITS +: wm_pkg::WM_LANE_BITS];
    assign cmd.col  = inst_reg[wm_pkg::WM_COL_BITS-1:0];
    assign cmd.data = data_reg;
    assign exec     = exec_reg;
    assign inputs   = inputs_reg;

    assign sum_offset = ar_addr_q - wm_pkg::ADDR_SUM0;

    always_comb begin
        case (ar_addr_q)
            wm_pkg::ADDR_DATA:  rd_value = 32'(data_reg);
            wm_pkg::ADDR_INST:  rd_value = 32'(inst_reg);
            wm_pkg::ADDR_CTRL:  rd_value = 32'(exec_reg);
            wm_pkg::ADDR_READ:  rd_value = 32'($signed(read_reg));
            wm_pkg::ADDR_INPUT: rd_value = 32'(inputs_reg);
            default: begin
                if (in_map(ar_addr_q)) begin
                    rd_value = 32'($signed(sums[sum_offset[wm_pkg::WM_COL_BITS+1:2]]));
                end else begin
                    rd_value = '0;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            aw_done    <= 1'b0;
            w_done     <= 1'b0;
            ar_done    <= 1'b0;
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            data_reg   <= '0;
            inst_reg   <= '0;
            exec_reg   <= 1'b0;
            inputs_reg <= '0;
        end else begin
            if (awvalid && awready) aw_done <= 1'b1;
            if (wvalid && wready) w_done <= 1'b1;

            if (wr_commit) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
                bvalid  <= 1'b1;
                if (wr_full) begin
                    case (aw_addr_q)
                        wm_pkg::ADDR_DATA:  data_reg   <= w_data_q[wm_pkg::WM_DATA_BITS-1:0];
                        wm_pkg::ADDR_INST:  inst_reg   <= w_data_q[wm_pkg::WM_INST_BITS-1:0];
                        wm_pkg::ADDR_CTRL:  exec_reg   <= w_data_q[0];
                        wm_pkg::ADDR_INPUT: inputs_reg <= w_data_q;
                        default: ; // READ and the sums are read only.
                    endcase
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            if (arvalid && arready) begin
                ar_done <= 1'b1;
            end else if (ar_done) begin
                ar_done <= 1'b0;
                rvalid  <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) aw_addr_q <= awaddr;
        if (wvalid && wready) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (wr_commit) begin
            bresp <= in_map(aw_addr_q) ? wm_pkg::RESP_OKAY : wm_pkg::RESP_SLVERR;
        end
        if (arvalid && arready) ar_addr_q <= araddr;
        if (ar_done) begin
            rdata <= rd_value;
            rresp <= in_map(ar_addr_q) ? wm_pkg::RESP_OKAY : wm_pkg::RESP_SLVERR;
        end
    end

endmodule : wm_axil_regs

//--- verilog/wm_pkg.sv
package wm_pkg;

    // Array geometry.
    localparam int WM_WIDTH     = 8;
    localparam int WM_DEPTH     = 4;
    localparam int WM_BITWIDTH  = 8;
    localparam int WM_IN_BITS   = 4;
    localparam int WM_SUM_BITS  = 16;
    localparam int WM_LANE_BITS = 3;
    localparam int WM_COL_BITS  = 2;

    // One 2-bit increment per lane, and the set value sits in the low byte.
    localparam int WM_DATA_BITS = 2 * WM_WIDTH;
    localparam int WM_INST_BITS = 1 + WM_LANE_BITS + WM_COL_BITS;

    localparam int AXI_ADDR_BITS = 6;
    localparam int AXI_DATA_BITS = 32;

    localparam logic [AXI_ADDR_BITS-1:0] ADDR_DATA  = 6'h00;
    localparam logic [AXI_ADDR_BITS-1:0] ADDR_INST  = 6'h04;
    localparam logic [AXI_ADDR_BITS-1:0] ADDR_CTRL  = 6'h08;
    localparam logic [AXI_ADDR_BITS-1:0] ADDR_READ  = 6'h0C;
    localparam logic [AXI_ADDR_BITS-1:0] ADDR_INPUT = 6'h10;
    localparam logic [AXI_ADDR_BITS-1:0] ADDR_SUM0  = 6'h14; // SUM1..SUM3 follow every 4 bytes.

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic {
        OP_SET       = 1'b0,
        OP_INCREMENT = 1'b1
    } wm_op_t;

    typedef enum logic {
        READY = 1'b0,
        HALT  = 1'b1
    } manager_state_t;

    typedef struct packed {
        wm_op_t                  op;
        logic [WM_LANE_BITS-1:0] lane;
        logic [WM_COL_BITS-1:0]  col;
        logic [WM_DATA_BITS-1:0] data;
    } wm_cmd_t;

    // Indexed as [lane][col], each element a two's complement weight.
    typedef logic [WM_WIDTH-1:0][WM_DEPTH-1:0][WM_BITWIDTH-1:0] wm_weights_t;

    typedef logic [WM_WIDTH-1:0][WM_IN_BITS-1:0] wm_inputs_t;

    typedef logic [WM_DEPTH-1:0][WM_SUM_BITS-1:0] wm_sums_t;

endpackage : wm_pkg

//--- verilog/wm_top.sv
`timescale 1ns/100ps

module wm_top (
    input  logic                               clk,
    input  logic                               rstb,
    input  logic [wm_pkg::AXI_ADDR_BITS-1:0]   awaddr,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [wm_pkg::AXI_DATA_BITS-1:0]   wdata,
    input  logic [wm_pkg::AXI_DATA_BITS/8-1:0] wstrb,
    input  logic                               wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,
    input  logic [wm_pkg::AXI_ADDR_BITS-1:0]   araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic [wm_pkg::AXI_DATA_BITS-1:0]   rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready
);

    wm_pkg::wm_cmd_t                       cmd;
    logic                                  exec;
    wm_pkg::wm_inputs_t                    inputs;
    logic signed [wm_pkg::WM_BITWIDTH-1:0] read_reg;
    wm_pkg::wm_weights_t                   weights;
    wm_pkg::wm_sums_t                      sums;

    wm_axil_regs u_regs (
        .clk      (clk),
        .rstb     (rstb),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .cmd      (cmd),
        .exec     (exec),
        .inputs   (inputs),
        .read_reg (read_reg),
        .sums     (sums)
    );

    weight_manager u_manager (
        .clk      (clk),
        .rstb     (rstb),
        .cmd      (cmd),
        .exec     (exec),
        .read_reg (read_reg),
        .weights  (weights)
    );

    dot_product_array u_dot (
        .clk     (clk),
        .rstb    (rstb),
        .weights (weights),
        .inputs  (inputs),
        .sums    (sums)
    );

endmodule : wm_top

//--- wm.f
verilog/wm_pkg.sv
verilog/wm_axil_regs.sv
verilog/weight_manager.sv
verilog/dot_product_array.sv
verilog/wm_top.sv
testbench/wm_checker.sv
testbench/wm_tb.sv
